// File: bias_bank.sv
////////////////////////////////////////////////////////////
// Bias register file, sixteen entries
// Group pointer selects the four biases in use
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module bias_bank
  import fc_arith_pkg::*, fc_stream_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      bias_we,
  input  class_t    bias_addr,
  input  sample_t   bias_data,
  input  logic      group_take,
  input  logic      frame_end,
  output bias_grp_t biases,
  output group_t    group
);

  sample_t bias_mem [NUM_LANES*NUM_GROUPS];

  // Written by the host while the engine is idle
  always_ff @(posedge clk) begin
    if (bias_we) begin
      bias_mem[bias_addr] <= bias_data;
    end
  end

  // One step per finished group, back to zero at the end of a frame
  always_ff @(posedge clk) begin
    if (!rstn) begin
      group <= '0;
    end else if (group_take) begin
      if (frame_end) begin
        group <= '0;
      end else begin
        group <= group + 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      biases.bias[i] = bias_mem[{group, LANE_W'(i)}];
    end
  end

  // Host writes and result consumption never overlap
  assert property (@(posedge clk) disable iff (!rstn) !(bias_we && group_take))
    else $error("Bias write while a group is being consumed");

endmodule

// File: dot_engine.sv
////////////////////////////////////////////////////////////
// Four MAC lanes sharing one feature per beat
// Tag pipeline for valid, clear, last and frame_last
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dot_engine
  import fc_arith_pkg::*, fc_stream_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      in_valid,
  input  logic      advance,
  input  in_beat_t  in_beat,
  output logic      res_valid,
  output lane_res_t res
);

  typedef struct packed {
    logic valid;
    logic clear;
    logic last;
    logic frame_last;
  } tag_t;

  tag_t       tag_q [ACC_LATENCY];
  logic       start_q;
  logic       accept;
  sample_t    feat_gated;
  acc_t       lane_acc [NUM_LANES];
  logic [3:0] lasts_open;

  assign accept = in_valid && advance;

  // Bubbles multiply by zero so the sums are left alone
  assign feat_gated = accept ? in_beat.feat : '0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      start_q <= 1'b1;
      for (int i = 0; i < ACC_LATENCY; i++) begin
        tag_q[i] <= '0;
      end
    end else if (advance) begin
      // Beat after a last beat opens the next dot product
      if (in_valid) begin
        start_q <= in_beat.last;
      end
      tag_q[0] <= {accept, accept & start_q, accept & in_beat.last,
                   accept & in_beat.frame_last};
      for (int i = 1; i < ACC_LATENCY; i++) begin
        tag_q[i] <= tag_q[i-1];
      end
    end
  end

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    mac_lane u_lane (
      .clk     (clk),
      .rstn    (rstn),
      .advance (advance),
      .feat    (feat_gated),
      .weight  (in_beat.weight[l]),
      .clear   (tag_q[MUL_STAGES-1].clear),
      .acc     (lane_acc[l])
    );
  end

  // Tag at the last slot lines up with the accumulator output
  assign res_valid = tag_q[ACC_LATENCY-1].valid && tag_q[ACC_LATENCY-1].last;

  always_comb begin
    res.frame_last = tag_q[ACC_LATENCY-1].frame_last;
    for (int l = 0; l < NUM_LANES; l++) begin
      res.acc[l] = lane_acc[l];
    end
  end

  // Last beats accepted and not yet handed to the result stage
  always_ff @(posedge clk) begin
    if (!rstn) begin
      lasts_open <= '0;
    end else if (advance) begin
      lasts_open <= lasts_open + 4'(accept && in_beat.last) - 4'(res_valid);
    end
  end

  assert property (@(posedge clk) disable iff (!rstn) res_valid |-> lasts_open != '0)
    else $error("Result valid without a last beat behind it");

endmodule

// File: fc_arith_pkg.sv
////////////////////////////////////////////////////////////
// Widths and arithmetic vector types of the FC layer engine
// Multiplier pipeline depth, bias scaling and the
// requantization window
////////////////////////////////////////////////////////////
package fc_arith_pkg;

  // Data widths
  localparam int SAMPLE_W = 8;
  localparam int PROD_W   = 16;
  localparam int ACC_W    = 28;
  localparam int CLASS_W  = 4;
  localparam int GROUP_W  = 2;
  localparam int LANE_W   = 2;

  // Neurons per group and groups per frame
  localparam int NUM_LANES  = 4;
  localparam int NUM_GROUPS = 4;

  // Pipeline depth, accumulator sits one stage behind the multiplier
  localparam int MUL_STAGES  = 8;
  localparam int ACC_LATENCY = 9;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic        [SAMPLE_W-1:0] mag_t;
  typedef logic signed [PROD_W-1:0]   prod_t;
  typedef logic signed [ACC_W-1:0]    acc_t;
  typedef logic        [CLASS_W-1:0]  class_t;
  typedef logic        [GROUP_W-1:0]  group_t;

  // Bias is aligned to the product scale
  localparam int BIAS_SHIFT = 6;

  // Requantization keeps bits Q_MSB down to Q_LSB
  localparam int      Q_LSB    = 6;
  localparam int      Q_MSB    = 12;
  localparam sample_t Q_MAX    = 8'sh7f;
  localparam sample_t MAX_INIT = 8'sh80;

endpackage

// File: fc_core.sv
////////////////////////////////////////////////////////////
// FC layer engine top level
// MAC engine and bias bank side by side, result stage after
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module fc_core
  import fc_arith_pkg::*, fc_stream_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      in_valid,
  output logic      in_ready,
  input  in_beat_t  in_beat,
  output logic      out_valid,
  input  logic      out_ready,
  output out_word_t out_word,
  input  logic      bias_we,
  input  class_t    bias_addr,
  input  sample_t   bias_data,
  output class_t    class_idx,
  output logic      frame_done
);

  logic      advance;
  logic      res_valid;
  lane_res_t res;
  bias_grp_t biases;
  group_t    group;
  logic      group_take;
  logic      frame_end;

  // Input accepts exactly when the pipeline moves
  assign in_ready = advance;

  dot_engine u_engine (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .advance   (advance),
    .in_beat   (in_beat),
    .res_valid (res_valid),
    .res       (res)
  );

  bias_bank u_bias (
    .clk        (clk),
    .rstn       (rstn),
    .bias_we    (bias_we),
    .bias_addr  (bias_addr),
    .bias_data  (bias_data),
    .group_take (group_take),
    .frame_end  (frame_end),
    .biases     (biases),
    .group      (group)
  );

  result_stage u_result (
    .clk        (clk),
    .rstn       (rstn),
    .res_valid  (res_valid),
    .res        (res),
    .biases     (biases),
    .group      (group),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .advance    (advance),
    .group_take (group_take),
    .frame_end  (frame_end),
    .class_idx  (class_idx),
    .frame_done (frame_done)
  );

endmodule

// File: fc_stream_pkg.sv
////////////////////////////////////////////////////////////
// Packed structs carried between the FC engine blocks
// Input beats, lane sums, bias groups and output words
////////////////////////////////////////////////////////////
package fc_stream_pkg;

  import fc_arith_pkg::*;

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////

  // One multiply step: a shared feature and one weight per lane
  typedef struct packed {
    sample_t                 feat;
    sample_t [NUM_LANES-1:0] weight;
    logic                    last;
    logic                    frame_last;
  } in_beat_t;

  ////////////////////////////////////////////////////////////
  // Engine to result stage
  ////////////////////////////////////////////////////////////

  // Finished dot products of one group
  typedef struct packed {
    acc_t [NUM_LANES-1:0] acc;
    logic                 frame_last;
  } lane_res_t;

  // Biases of the group currently in the result stage
  typedef struct packed {
    sample_t [NUM_LANES-1:0] bias;
  } bias_grp_t;

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////

  // Requantized neuron outputs, lane 0 in the low byte
  typedef struct packed {
    sample_t [NUM_LANES-1:0] q;
  } out_word_t;

endpackage

// File: list.f
fc_arith_pkg.sv
fc_stream_pkg.sv
mac_lane.sv
dot_engine.sv
bias_bank.sv
result_stage.sv
fc_core.sv
tb_fc_core.sv

// File: mac_lane.sv
////////////////////////////////////////////////////////////
// One signed MAC lane
// Sign-magnitude partial products, eight-stage adder tree
// and a 28-bit accumulator
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mac_lane
  import fc_arith_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  logic    advance,
  input  sample_t feat,
  input  sample_t weight,
  input  logic    clear,
  output acc_t    acc
);

  mag_t feat_mag;
  mag_t weight_mag;

  // Sign of the product rides alongside stages 1 to 7
  logic [MUL_STAGES-2:0] sign_pipe;

  mag_t       s1_pp [8];
  logic [5:0] s2_lsb [4];
  logic [2:0] s2_hi_a [4];
  logic [3:0] s2_hi_b [4];
  logic [4:0] s3_hi [4];
  logic [9:0] s3_sum [4];
  logic [7:0] s4_lsb [2];
  logic [2:0] s4_hi_a [2];
  logic [4:0] s4_hi_b [2];
  logic [4:0] s5_hi [2];
  logic [11:0] s5_sum [2];
  logic [9:0] s6_lsb;
  logic [2:0] s6_hi_a;
  logic [6:0] s6_hi_b;
  logic [6:0] s7_hi;
  logic [15:0] s7_sum;
  prod_t      prod_q;

  assign feat_mag   = feat[SAMPLE_W-1] ? mag_t'(~feat + 8'd1) : mag_t'(feat);
  assign weight_mag = weight[SAMPLE_W-1] ? mag_t'(~weight + 8'd1) : mag_t'(weight);

  // Carry-in of each upper half comes from the lower half of the stage before
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      s3_hi[i] = {2'b00, s2_hi_a[i]} + {1'b0, s2_hi_b[i]} + {4'b0000, s2_lsb[i][5]};
    end
    for (int j = 0; j < 2; j++) begin
      s5_hi[j] = {2'b00, s4_hi_a[j]} + s4_hi_b[j] + {4'b0000, s4_lsb[j][7]};
    end
    s7_hi = {4'b0000, s6_hi_a} + s6_hi_b + {6'b000000, s6_lsb[9]};
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      // Stage 1, partial products
      for (int i = 0; i < 8; i++) begin
        s1_pp[i] <= weight_mag[i] ? feat_mag : '0;
      end
      sign_pipe <= {sign_pipe[MUL_STAGES-3:0], feat[SAMPLE_W-1] ^ weight[SAMPLE_W-1]};

      // Stage 2, low halves of adjacent pairs
      for (int i = 0; i < 4; i++) begin
        s2_lsb[i]  <= {1'b0, s1_pp[2*i][4:0]} + {1'b0, s1_pp[2*i+1][3:0], 1'b0};
        s2_hi_a[i] <= s1_pp[2*i][7:5];
        s2_hi_b[i] <= s1_pp[2*i+1][7:4];
      end

      // Stage 3, high halves
      for (int i = 0; i < 4; i++) begin
        s3_sum[i] <= {s3_hi[i], s2_lsb[i][4:0]};
      end

      // Stage 4, pairs weighted by four
      for (int j = 0; j < 2; j++) begin
        s4_lsb[j]  <= {1'b0, s3_sum[2*j][6:0]} + {1'b0, s3_sum[2*j+1][4:0], 2'b00};
        s4_hi_a[j] <= s3_sum[2*j][9:7];
        s4_hi_b[j] <= s3_sum[2*j+1][9:5];
      end

      // Stage 5
      for (int j = 0; j < 2; j++) begin
        s5_sum[j] <= {s5_hi[j], s4_lsb[j][6:0]};
      end

      // Stage 6, final pair weighted by sixteen
      s6_lsb  <= {1'b0, s5_sum[0][8:0]} + {1'b0, s5_sum[1][4:0], 4'b0000};
      s6_hi_a <= s5_sum[0][11:9];
      s6_hi_b <= s5_sum[1][11:5];

      // Stage 7, unsigned product
      s7_sum <= {s7_hi, s6_lsb[8:0]};

      // Stage 8, apply the sign
      prod_q <= sign_pipe[MUL_STAGES-2] ? prod_t'(~s7_sum + 16'd1) : prod_t'(s7_sum);

      // First product of a dot product replaces the old sum
      acc <= clear ? acc_t'(prod_q) : acc + acc_t'(prod_q);
    end
  end

  // A stalled lane must hold its sum for the result stage
  assert property (@(posedge clk) disable iff (!rstn) !advance |=> $stable(acc))
    else $error("MAC accumulator moved during a stall");

endmodule

// File: result_stage.sv
////////////////////////////////////////////////////////////
// Bias add, requantization and running argmax
// Output register with valid/ready handshake
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module result_stage
  import fc_arith_pkg::*, fc_stream_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      res_valid,
  input  lane_res_t res,
  input  bias_grp_t biases,
  input  group_t    group,
  input  logic      out_ready,
  output logic      out_valid,
  output out_word_t out_word,
  output logic      advance,
  output logic      group_take,
  output logic      frame_end,
  output class_t    class_idx,
  output logic      frame_done
);

  acc_t    biased [NUM_LANES];
  sample_t q [NUM_LANES];
  sample_t run_max;
  class_t  run_idx;
  sample_t max_q;
  class_t  idx_q;
  logic    load;

  // Whole pipeline stalls only while a word waits on the output
  assign advance = !(out_valid && !out_ready);

  assign load       = res_valid && advance;
  assign group_take = load;
  assign frame_end  = load && res.frame_last;

  ////////////////////////////////////////////////////////////
  // Bias, requantization and argmax over the four lanes
  ////////////////////////////////////////////////////////////
  always_comb begin
    run_max = max_q;
    run_idx = idx_q;
    for (int i = 0; i < NUM_LANES; i++) begin
      biased[i] = res.acc[i] + (acc_t'(biases.bias[i]) <<< BIAS_SHIFT);
      if (biased[i][ACC_W-1]) begin
        // ReLU
        q[i] = '0;
      end else if (|biased[i][ACC_W-2:Q_MSB]) begin
        q[i] = Q_MAX;
      end else begin
        q[i] = sample_t'(biased[i][Q_MSB:Q_LSB]);
      end
      // Strictly greater, so the lower index keeps a tie
      if (q[i] > run_max) begin
        run_max = q[i];
        run_idx = {group, LANE_W'(i)};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register and frame result
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid  <= 1'b0;
      frame_done <= 1'b0;
      max_q      <= MAX_INIT;
      idx_q      <= '0;
      class_idx  <= '0;
    end else begin
      frame_done <= frame_end;
      if (load) begin
        out_valid <= 1'b1;
        if (res.frame_last) begin
          class_idx <= run_idx;
          max_q     <= MAX_INIT;
        end else begin
          max_q <= run_max;
          idx_q <= run_idx;
        end
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        out_word.q[i] <= q[i];
      end
    end
  end

  // Held word stays put until the consumer takes it
  assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_word))
    else $error("Output word changed under back-pressure");

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compile and run the FC core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_fc_core -o sim_fc_core
./obj_dir/sim_fc_core | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

// File: tb_fc_core.sv
////////////////////////////////////////////////////////////
// Testbench for the FC layer engine
// Clock and reset, stream stimulus, reference model,
// output and frame checks, handshake assertions
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_fc_core
  import fc_arith_pkg::*, fc_stream_pkg::*;
();

  localparam int TIMEOUT = 1000;

  logic      clk;
  logic      rstn;
  logic      in_valid;
  logic      in_ready;
  in_beat_t  in_beat;
  logic      out_valid;
  logic      out_ready = 1'b1;
  out_word_t out_word;
  logic      bias_we;
  class_t    bias_addr;
  sample_t   bias_data;
  class_t    class_idx;
  logic      frame_done;

  // Reference model state and expected results
  out_word_t exp_q [$];
  class_t    class_q [$];
  sample_t   bias_ref [16];
  group_t    grp_ref;
  sample_t   max_ref;
  class_t    idx_ref;
  sample_t   feat_buf [16];
  sample_t   w_buf [16][NUM_LANES];

  int   err_cnt;
  int   test_err0;
  int   fail_tests;
  int   frames_seen;
  int   len;
  int   lat;
  logic stall_en;
  logic timed_out;

  fc_core DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Consumer stalls about one cycle in three during the stall test
  always @(posedge clk) begin
    out_ready <= stall_en ? ($urandom % 3 != 0) : 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Output and frame checks
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    out_word_t exp_word;
    class_t    exp_cls;
    if (rstn && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Output word %h at %0t arrived with none pending", out_word, $time);
      end else begin
        exp_word = exp_q.pop_front();
        assert (out_word == exp_word) else begin
          err_cnt++;
          $display("ERR %0t: out_word %h, expected %h", $time, out_word, exp_word);
        end
      end
    end
    if (rstn && frame_done) begin
      frames_seen++;
      if (class_q.size() == 0) begin
        err_cnt++;
        $display("frame_done pulsed at %0t with no frame pending", $time);
      end else begin
        exp_cls = class_q.pop_front();
        assert (class_idx == exp_cls) else begin
          err_cnt++;
          $display("ERR %0t: class_idx %0d, expected %0d", $time, class_idx, exp_cls);
        end
      end
    end
  end

  // A held word must not move until it is taken
  assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_word))
    else begin
      err_cnt++;
      $display("ERR %0t: out_word changed while held", $time);
    end

  assert property (@(posedge clk) disable iff (!rstn)
    in_ready == !(out_valid && !out_ready))
    else begin
      err_cnt++;
      $display("ERR %0t: in_ready does not follow back-pressure", $time);
    end

  ////////////////////////////////////////////////////////////
  // Reference model and drivers
  ////////////////////////////////////////////////////////////

  // Sum in accumulator units to one output byte
  function automatic sample_t requant_ref(input int v);
    if (v < 0) return 8'sd0;
    if (v >= 4096) return 8'sd127;
    return sample_t'(v / 64);
  endfunction

  function automatic sample_t small_rand();
    return sample_t'(int'($urandom % 21) - 10);
  endfunction

  task automatic fill_operands(input int n, input logic narrow);
    for (int k = 0; k < n; k++) begin
      feat_buf[k] = narrow ? small_rand() : sample_t'($urandom);
      for (int l = 0; l < NUM_LANES; l++) begin
        w_buf[k][l] = narrow ? small_rand() : sample_t'($urandom);
      end
    end
  endtask

  task automatic send_beat(input in_beat_t b);
    int n;
    if (timed_out) return;
    in_valid <= 1'b1;
    in_beat  <= b;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!in_ready && n < TIMEOUT);
    if (!in_ready) begin
      timed_out = 1'b1;
      $display("Timeout at %0t: an input beat was never accepted", $time);
    end
  endtask

  // Predicts the word and the argmax, then sends the beats
  task automatic send_dot(input int n, input logic fl);
    in_beat_t  b;
    out_word_t w;
    sample_t   qv [NUM_LANES];
    int        sum;
    for (int l = 0; l < NUM_LANES; l++) begin
      sum = int'(bias_ref[int'(grp_ref) * 4 + l]) * 64;
      for (int k = 0; k < n; k++) begin
        sum += int'(feat_buf[k]) * int'(w_buf[k][l]);
      end
      qv[l] = requant_ref(sum);
      w.q[l] = qv[l];
      // Only a strictly larger value takes over
      if (qv[l] > max_ref) begin
        max_ref = qv[l];
        idx_ref = class_t'(int'(grp_ref) * 4 + l);
      end
    end
    exp_q.push_back(w);
    if (fl) begin
      class_q.push_back(idx_ref);
      max_ref = 8'sh80;
      grp_ref = '0;
    end else begin
      grp_ref = group_t'(int'(grp_ref) + 1);
    end
    for (int k = 0; k < n; k++) begin
      b.feat       = feat_buf[k];
      b.last       = (k == n - 1);
      b.frame_last = fl && (k == n - 1);
      for (int l = 0; l < NUM_LANES; l++) begin
        b.weight[l] = w_buf[k][l];
      end
      send_beat(b);
    end
  endtask

  task automatic wait_drain();
    int n;
    in_valid <= 1'b0;
    if (timed_out) return;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while ((exp_q.size() != 0 || out_valid) && n < TIMEOUT);
    if (exp_q.size() != 0 || out_valid) begin
      timed_out = 1'b1;
      $display("Timeout at %0t: %0d output words never arrived", $time, exp_q.size());
    end
  endtask

  task automatic load_biases(input logic zero);
    for (int i = 0; i < 16; i++) begin
      bias_ref[i] = zero ? 8'sd0 : sample_t'(int'($urandom % 64) - 32);
      bias_we   <= 1'b1;
      bias_addr <= class_t'(i);
      bias_data <= bias_ref[i];
      @(posedge clk);
    end
    bias_we <= 1'b0;
  endtask

  task automatic reset_dut();
    rstn <= 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    grp_ref = '0;
    max_ref = 8'sh80;
    idx_ref = '0;
    @(posedge clk);
  endtask

  task automatic finish_test(input int num, input string name);
    if (err_cnt != test_err0 || timed_out) begin
      fail_tests++;
      $display("Test %0d, %s: failed", num, name);
    end else begin
      $display("Test %0d, %s: passed", num, name);
    end
    test_err0 = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h2749_0451));
    err_cnt     = 0;
    test_err0   = 0;
    fail_tests  = 0;
    frames_seen = 0;
    stall_en    = 1'b0;
    timed_out   = 1'b0;
    rstn      <= 1'b0;
    in_valid  <= 1'b0;
    in_beat   <= '0;
    bias_we   <= 1'b0;
    bias_addr <= '0;
    bias_data <= '0;
    reset_dut();

    assert (!out_valid && !frame_done && in_ready) else begin
      err_cnt++;
      $display("ERR %0t: outputs not idle after reset", $time);
    end
    finish_test(1, "reset state");

    // Single dot product with extreme operands
    load_biases(1'b1);
    len = 1 + int'($urandom % 8);
    fill_operands(len, 1'b0);
    feat_buf[0]       = 8'sh80;
    w_buf[0][0]       = 8'sh80;
    w_buf[len-1][3]   = 8'sh80;
    send_dot(len, 1'b0);
    in_valid <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!out_valid && lat < TIMEOUT);
    assert (lat == 10) else begin
      err_cnt++;
      $display("ERR %0t: out_valid rose %0d cycles after the last beat, expected 10",
               $time, lat);
    end
    wait_drain();
    finish_test(2, "single dot product and latency");

    for (int d = 0; d < 5; d++) begin
      len = 1 + int'($urandom % 6);
      fill_operands(len, 1'b0);
      send_dot(len, 1'b0);
    end
    wait_drain();
    finish_test(3, "back-to-back dot products");

    stall_en = 1'b1;
    for (int d = 0; d < 6; d++) begin
      len = 1 + int'($urandom % 6);
      fill_operands(len, 1'b0);
      send_dot(len, 1'b0);
    end
    wait_drain();
    stall_en = 1'b0;
    finish_test(4, "output back-pressure");

    // Lane 0 goes negative, lane 1 saturates, lanes 2 and 3 show the bias
    load_biases(1'b0);
    feat_buf[0] = 8'sd100;
    feat_buf[1] = 8'sd100;
    w_buf[0] = '{-8'sd100, 8'sd100, 8'sd0, 8'sd1};
    w_buf[1] = '{-8'sd100, 8'sd100, 8'sd0, -8'sd1};
    send_dot(2, 1'b0);
    for (int d = 0; d < 3; d++) begin
      fill_operands(3, 1'b1);
      send_dot(3, 1'b0);
    end
    wait_drain();
    finish_test(5, "bias, clipping and saturation");

    // Neurons 6, 8 and 11 all saturate and the lowest one must win
    reset_dut();
    load_biases(1'b1);
    frames_seen = 0;
    fill_operands(3, 1'b1);
    send_dot(3, 1'b0);
    for (int k = 0; k < 3; k++) begin
      feat_buf[k] = 8'sd100;
      w_buf[k] = '{8'sd1, -8'sd1, 8'sd100, 8'sd0};
    end
    send_dot(3, 1'b0);
    for (int k = 0; k < 3; k++) begin
      w_buf[k] = '{8'sd100, 8'sd2, -8'sd3, 8'sd100};
    end
    send_dot(3, 1'b1);
    wait_drain();
    @(posedge clk);
    if (frames_seen != 1 || class_q.size() != 0) begin
      err_cnt++;
      $display("frame_done pulsed %0d times for one frame", frames_seen);
    end
    finish_test(6, "frame argmax");

    $display("Summary: 6 tests, %0d failed, %0d errors", fail_tests, err_cnt);
    if (err_cnt == 0 && fail_tests == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
